//--- common/fg_pkg.sv
package fg_pkg;

	// accelerator geometry
	// rf buckets in one revolution of the ring
	localparam int rf_buckets = 5120;

	// off between on, two output bits per bucket
	localparam int bucket_scaling = 2;

	// width of one serializer word
	localparam int bits_per_word = 8;

	// words making up one full revolution
	// 5120 * 2 / 8 = 1280
	localparam int words_per_turn = rf_buckets * bucket_scaling / bits_per_word;

	// idle clocks after reset before the memory fill starts
	localparam int reset_hold_cycles = 128;

	// bring-up order: hold, fill memory, one sync pulse, then play forever
	typedef enum logic [1:0] {state_hold, state_load, state_sync, state_run} bringup_state_t;

endpackage

//--- hdl/bringup_sequencer.sv
`timescale 1ns/10ps

module bringup_sequencer import fg_pkg::*; (
	input  logic clock50,
	input  logic reset1,
	input  logic load_done,
	output logic load_enable,
	output logic sync,
	output logic run
);

	// hold counter spans reset_hold_cycles clocks
	localparam int hold_bits = $clog2(reset_hold_cycles);
	localparam logic [hold_bits-1:0] last_hold = hold_bits'(reset_hold_cycles - 1);

	bringup_state_t state;
	logic [hold_bits-1:0] hold_count;

	always_ff @(posedge clock50) begin
		if (reset1) begin
			// back to the start from anywhere
			state <= state_hold;
			hold_count <= '0;
		end else begin
			case (state)
				state_hold: begin
					// wait out the hold time, then start filling
					if (hold_count == last_hold) begin
						state <= state_load;
					end else begin
						hold_count <= hold_count + 1'b1;
					end
				end
				state_load: begin
					// loader keeps load_done high once the fill is over
					if (load_done) begin
						state <= state_sync;
					end
				end
				state_sync: begin
					// exactly one cycle here, so one sync pulse per bring-up
					state <= state_run;
				end
				default: begin
					// run is terminal until the next reset
					state <= state_run;
				end
			endcase
		end
	end

	// outputs decoded straight from the state
	assign load_enable = (state == state_load);
	assign sync = (state == state_sync);
	assign run = (state == state_run);

endmodule

//--- function_generator/pattern_loader.sv
`timescale 1ns/10ps

module pattern_loader import fg_pkg::*; #(
	parameter int DATA_BUS_WIDTH = bits_per_word,
	parameter int ADDRESS_BUS_DEPTH = 11
) (
	input  logic clock50,
	input  logic reset1,
	input  logic load_enable,
	output logic [ADDRESS_BUS_DEPTH-1:0] write_address,
	output logic [DATA_BUS_WIDTH-1:0] write_data,
	output logic write_enable,
	output logic load_done
);

	// a pulse every 128 words, width taken from the next three address bits
	localparam int spacing_bits = 7;
	localparam int width_bits = 3;
	localparam logic [ADDRESS_BUS_DEPTH-1:0] last_address = '1;

	logic [ADDRESS_BUS_DEPTH-1:0] count;
	logic last_write;
	logic issue;

	// thermometer word, n ones from the msb, n = 1 + address[9:7]
	function automatic logic [DATA_BUS_WIDTH-1:0] pulse_word(
		input logic [ADDRESS_BUS_DEPTH-1:0] address
	);
		logic [DATA_BUS_WIDTH-1:0] ones;
		logic [width_bits:0] width;
		ones = '1;
		width = {1'b0, address[spacing_bits +: width_bits]} + 1'b1;
		if (address[spacing_bits-1:0] == '0) begin
			return ~(ones >> width);
		end
		return '0;
	endfunction

	// top address currently on the write port
	assign last_write = write_enable && (write_address == last_address);
	// one new address per clock until the top one has gone out
	assign issue = load_enable && !load_done && !last_write;

	always_ff @(posedge clock50) begin
		if (reset1) begin
			count <= '0;
			write_enable <= 1'b0;
			load_done <= 1'b0;
		end else begin
			write_enable <= issue;
			if (issue) begin
				count <= count + 1'b1;
			end
			// sticky until reset, nothing written after it
			if (last_write) begin
				load_done <= 1'b1;
			end
		end
	end

	// address and data only matter while write_enable is high
	always_ff @(posedge clock50) begin
		if (issue) begin
			write_address <= count;
			write_data <= pulse_word(count);
		end
	end

endmodule

//--- function_generator/waveform_ram.sv
`timescale 1ns/10ps

module waveform_ram import fg_pkg::*; #(
	parameter int DATA_BUS_WIDTH = bits_per_word,
	parameter int ADDRESS_BUS_DEPTH = 11
) (
	input  logic clock50,
	input  logic write_enable,
	input  logic [ADDRESS_BUS_DEPTH-1:0] write_address,
	input  logic [DATA_BUS_WIDTH-1:0] write_data,
	input  logic [ADDRESS_BUS_DEPTH-1:0] read_address,
	output logic [DATA_BUS_WIDTH-1:0] read_data
);

	// one word per address, maps onto block ram
	localparam int words = 2 ** ADDRESS_BUS_DEPTH;

	logic [DATA_BUS_WIDTH-1:0] memory [0:words-1];

	// write port, filled once by the loader
	always_ff @(posedge clock50) begin
		if (write_enable) begin
			memory[write_address] <= write_data;
		end
	end

	// registered read
	// data is valid one clock after the address
	always_ff @(posedge clock50) begin
		read_data <= memory[read_address];
	end

endmodule

//--- function_generator/playback_address_counter.sv
`timescale 1ns/10ps

module playback_address_counter import fg_pkg::*; #(
	parameter int DATA_BUS_WIDTH = bits_per_word,
	parameter int ADDRESS_BUS_DEPTH = 11,
	parameter int START_WORD = 0,
	parameter int END_WORD = words_per_turn
) (
	input  logic clock50,
	input  logic reset1,
	input  logic sync,
	input  logic run,
	output logic [ADDRESS_BUS_DEPTH-1:0] read_address,
	output logic word_load,
	output logic revolution
);

	// one slot per serialized bit
	localparam int slot_bits = $clog2(DATA_BUS_WIDTH);
	localparam logic [slot_bits-1:0] last_slot = slot_bits'(DATA_BUS_WIDTH - 1);
	// playback window, end word itself is not played
	localparam logic [ADDRESS_BUS_DEPTH-1:0] first_word = ADDRESS_BUS_DEPTH'(START_WORD);
	localparam logic [ADDRESS_BUS_DEPTH-1:0] last_word = ADDRESS_BUS_DEPTH'(END_WORD - 1);

	logic [slot_bits-1:0] slot;
	logic slot_zero;

	assign slot_zero = (slot == '0);

	always_ff @(posedge clock50) begin
		if (reset1) begin
			slot <= '0;
			read_address <= first_word;
			word_load <= 1'b0;
			revolution <= 1'b0;
		end else begin
			// slot zero strobe one clock late, lines up with read_data
			word_load <= run && slot_zero;
			// start of each turn marked with the start word's load
			revolution <= run && slot_zero && (read_address == first_word);
			if (sync) begin
				// realign both counts to the start of a turn
				slot <= '0;
				read_address <= first_word;
			end else if (run) begin
				if (slot == last_slot) begin
					slot <= '0;
					// step to next word, wrap at the end of the window
					if (read_address == last_word) begin
						read_address <= first_word;
					end else begin
						read_address <= read_address + 1'b1;
					end
				end else begin
					slot <= slot + 1'b1;
				end
			end
		end
	end

endmodule

//--- hdl/word_serializer.sv
`timescale 1ns/10ps

module word_serializer import fg_pkg::*; #(
	parameter int DATA_BUS_WIDTH = bits_per_word
) (
	input  logic clock50,
	input  logic reset1,
	input  logic word_load,
	input  logic [DATA_BUS_WIDTH-1:0] read_data,
	output logic bit_out
);

	// bits still waiting to go out, next one at the top
	logic [DATA_BUS_WIDTH-1:0] shift_register;

	always_ff @(posedge clock50) begin
		if (reset1) begin
			// zeros drain out before the first word arrives
			shift_register <= '0;
			bit_out <= 1'b0;
		end else if (word_load) begin
			// msb goes straight out, rest waits in the register
			bit_out <= read_data[DATA_BUS_WIDTH-1];
			shift_register <= read_data << 1;
		end else begin
			// one bit per clock, zero fill from the bottom
			bit_out <= shift_register[DATA_BUS_WIDTH-1];
			shift_register <= shift_register << 1;
		end
	end

endmodule

//--- hdl/function_generator_top.sv
`timescale 1ns/10ps

module function_generator_top import fg_pkg::*; #(
	parameter int DATA_BUS_WIDTH = bits_per_word,
	parameter int ADDRESS_BUS_DEPTH = 11,
	parameter int START_WORD = 0,
	parameter int END_WORD = words_per_turn
) (
	input  logic clock50,
	input  logic reset1,
	output logic bit_out,
	output logic revolution,
	output logic pattern_ready,
	output logic running
);

	// bring-up control
	logic load_enable;
	logic load_done;
	logic sync;
	logic run;
	// memory fill
	logic [ADDRESS_BUS_DEPTH-1:0] write_address;
	logic [DATA_BUS_WIDTH-1:0] write_data;
	logic write_enable;
	// playback
	logic [ADDRESS_BUS_DEPTH-1:0] read_address;
	logic [DATA_BUS_WIDTH-1:0] read_data;
	logic word_load;

	bringup_sequencer sequencer_i (
		.clock50(clock50),
		.reset1(reset1),
		.load_done(load_done),
		.load_enable(load_enable),
		.sync(sync),
		.run(run)
	);

	pattern_loader #(
		.DATA_BUS_WIDTH(DATA_BUS_WIDTH),
		.ADDRESS_BUS_DEPTH(ADDRESS_BUS_DEPTH)
	) loader_i (
		.clock50(clock50),
		.reset1(reset1),
		.load_enable(load_enable),
		.write_address(write_address),
		.write_data(write_data),
		.write_enable(write_enable),
		.load_done(load_done)
	);

	waveform_ram #(
		.DATA_BUS_WIDTH(DATA_BUS_WIDTH),
		.ADDRESS_BUS_DEPTH(ADDRESS_BUS_DEPTH)
	) ram_i (
		.clock50(clock50),
		.write_enable(write_enable),
		.write_address(write_address),
		.write_data(write_data),
		.read_address(read_address),
		.read_data(read_data)
	);

	playback_address_counter #(
		.DATA_BUS_WIDTH(DATA_BUS_WIDTH),
		.ADDRESS_BUS_DEPTH(ADDRESS_BUS_DEPTH),
		.START_WORD(START_WORD),
		.END_WORD(END_WORD)
	) counter_i (
		.clock50(clock50),
		.reset1(reset1),
		.sync(sync),
		.run(run),
		.read_address(read_address),
		.word_load(word_load),
		.revolution(revolution)
	);

	word_serializer #(
		.DATA_BUS_WIDTH(DATA_BUS_WIDTH)
	) serializer_i (
		.clock50(clock50),
		.reset1(reset1),
		.word_load(word_load),
		.read_data(read_data),
		.bit_out(bit_out)
	);

	// status levels brought out
	assign pattern_ready = load_done;
	assign running = run;

endmodule

//--- tb/function_generator_assertions.sv
`timescale 1ns/10ps

module function_generator_assertions import fg_pkg::*; #(
	parameter int DATA_BUS_WIDTH = bits_per_word,
	parameter int ADDRESS_BUS_DEPTH = 11,
	parameter int START_WORD = 0,
	parameter int END_WORD = words_per_turn
) (
	input logic clock50,
	input logic reset1,
	input logic bit_out,
	input logic revolution,
	input logic pattern_ready,
	input logic running
);

	// clocks after reset release at which the status levels rise
	localparam int ready_cycle = reset_hold_cycles + 2 ** ADDRESS_BUS_DEPTH + 1;
	localparam int run_cycle = ready_cycle + 2;

	int since_reset;
	// next expected bit with position 0 at the msb
	int word_index;
	int bit_index;
	logic model_valid;
	logic turn_end;
	logic error_seen = 1'b0;

	// pulse of 1 to 8 ones from the top on every 128th word
	function automatic logic pattern_bit(input int word, input int position);
		if (word % 128 != 0) begin
			return 1'b0;
		end
		return position <= (word / 128) % 8;
	endfunction

	always_ff @(posedge clock50) begin
		if (reset1) begin
			since_reset <= 0;
			model_valid <= 1'b0;
			word_index <= START_WORD;
			bit_index <= 0;
		end else begin
			// saturates well past the bring-up milestones
			if (since_reset < run_cycle + 16) begin
				since_reset <= since_reset + 1;
			end
			if (revolution) begin
				// msb of the start word follows on the next clock
				model_valid <= 1'b1;
				word_index <= START_WORD;
				bit_index <= 0;
			end else if (bit_index == DATA_BUS_WIDTH - 1) begin
				bit_index <= 0;
				word_index <= (word_index == END_WORD - 1) ? START_WORD : word_index + 1;
			end else begin
				bit_index <= bit_index + 1;
			end
		end
	end

	// last bit of the last word in the window
	assign turn_end = (word_index == END_WORD - 1) && (bit_index == DATA_BUS_WIDTH - 1);

	reset_clears: assert property (@(posedge clock50)
		reset1 |=> (!bit_out && !revolution && !running))
	else begin
		error_seen = 1'b1;
		$error("Mismatch at %0t: outputs not low during reset", $time);
	end

	// silent until playback
	quiet_before_run: assert property (@(posedge clock50) disable iff (reset1)
		!running |-> (!bit_out && !revolution))
	else begin
		error_seen = 1'b1;
		$error("Mismatch at %0t: bit_out or revolution high before running", $time);
	end

	ready_on_time: assert property (@(posedge clock50) disable iff (reset1)
		$rose(pattern_ready) == (since_reset == ready_cycle))
	else begin
		error_seen = 1'b1;
		$error("Mismatch at %0t: pattern_ready edge at clock %0d, expected %0d",
			$time, $sampled(since_reset), ready_cycle);
	end

	running_on_time: assert property (@(posedge clock50) disable iff (reset1)
		$rose(running) == (since_reset == run_cycle))
	else begin
		error_seen = 1'b1;
		$error("Mismatch at %0t: running edge at clock %0d, expected %0d",
			$time, $sampled(since_reset), run_cycle);
	end

	// first turn marker right behind running
	first_turn: assert property (@(posedge clock50) disable iff (reset1)
		$rose(running) |=> revolution)
	else begin
		error_seen = 1'b1;
		$error("Mismatch at %0t: no revolution one clock after running", $time);
	end

	turn_length: assert property (@(posedge clock50) disable iff (reset1)
		model_valid |-> (revolution == turn_end))
	else begin
		error_seen = 1'b1;
		$error("Mismatch at %0t: revolution is %b at word %0d bit %0d",
			$time, $sampled(revolution), $sampled(word_index), $sampled(bit_index));
	end

	bit_matches: assert property (@(posedge clock50) disable iff (reset1)
		model_valid |-> (bit_out == pattern_bit(word_index, bit_index)))
	else begin
		error_seen = 1'b1;
		$error("Mismatch at %0t: bit_out is %b at word %0d bit %0d",
			$time, $sampled(bit_out), $sampled(word_index), $sampled(bit_index));
	end

endmodule

//--- tb/function_generator_tb.sv
`timescale 1ns/10ps

module function_generator_tb import fg_pkg::*; ();

	localparam int half_period = 20;
	localparam int address_depth = 11;
	localparam int reset_cycles = 8;
	// reset, hold, fill and the steps up to the first revolution
	localparam int bringup_cycles = reset_cycles + reset_hold_cycles + 2 ** address_depth + 4;
	localparam int turn_cycles = words_per_turn * bits_per_word;
	// up to two turns before the second reset and two after it
	localparam int watchdog_cycles = 2 * bringup_cycles + 4 * turn_cycles + 1000;

	logic clock50;
	logic reset1;
	logic bit_out;
	logic revolution;
	logic pattern_ready;
	logic running;
	int reset_delay;

	function_generator_top #(
		.ADDRESS_BUS_DEPTH(address_depth),
		.START_WORD(0),
		.END_WORD(words_per_turn)
	) dut_i (
		.clock50(clock50),
		.reset1(reset1),
		.bit_out(bit_out),
		.revolution(revolution),
		.pattern_ready(pattern_ready),
		.running(running)
	);

	bind function_generator_top function_generator_assertions #(
		.DATA_BUS_WIDTH(DATA_BUS_WIDTH),
		.ADDRESS_BUS_DEPTH(ADDRESS_BUS_DEPTH),
		.START_WORD(START_WORD),
		.END_WORD(END_WORD)
	) checker_i (
		.clock50(clock50),
		.reset1(reset1),
		.bit_out(bit_out),
		.revolution(revolution),
		.pattern_ready(pattern_ready),
		.running(running)
	);

	initial begin
		clock50 = 1'b0;
		forever begin
			#(half_period) clock50 = ~clock50;
		end
	end

	// drop the already raised reset after the hold
	task automatic release_reset();
		repeat (reset_cycles) @(posedge clock50);
		#1 reset1 = 1'b0;
	endtask

	// sampled on the falling edge away from register updates
	task automatic wait_for_revolution();
		@(negedge clock50);
		while (!revolution) begin
			@(negedge clock50);
		end
	endtask

	initial begin
		reset1 = 1'b1;
		void'($urandom(32'hc0c6_14bf));
		release_reset();
		// first bring-up and then into the second turn
		wait_for_revolution();
		wait_for_revolution();
		// restart at a random point inside the second turn
		reset_delay = $urandom_range(turn_cycles - 2, 1);
		repeat (reset_delay) @(posedge clock50);
		#1 reset1 = 1'b1;
		release_reset();
		// second bring-up plus two whole turns
		repeat (3) wait_for_revolution();
		repeat (2) @(posedge clock50);
		if (dut_i.checker_i.error_seen) begin
			$display("tests failed");
			$fatal(1, "a bound assertion failed during the run");
		end else begin
			$display("all tests passed");
			$finish;
		end
	end

	// first assertion failure ends the run
	initial begin
		wait (dut_i.checker_i.error_seen);
		$display("tests failed");
		$fatal(1, "a bound assertion failed, see the error above");
	end

	initial begin
		repeat (watchdog_cycles) @(posedge clock50);
		$display("tests failed");
		$fatal(1, "watchdog expired before the expected revolutions were seen");
	end

endmodule

//--- files.f
common/fg_pkg.sv
hdl/bringup_sequencer.sv
function_generator/pattern_loader.sv
function_generator/waveform_ram.sv
function_generator/playback_address_counter.sv
hdl/word_serializer.sv
hdl/function_generator_top.sv
tb/function_generator_assertions.sv
tb/function_generator_tb.sv

//--- Makefile
VERILATOR = verilator
FLAGS = --binary --timing --assert -j 0
LINT_FLAGS = --lint-only --timing --assert
TOP = function_generator_tb
FILE_LIST = files.f
BUILD_DIR = obj_dir
RUN_ARGS = +verilator+error+limit+100

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILE_LIST)

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILE_LIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP) $(RUN_ARGS) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "all tests passed"

clean:
	rm -rf $(BUILD_DIR)
